// File: Makefile
# Verilator build for the bus fabric testbench
VERILATOR ?= verilator
TOP ?= soc_fabric_tb
FILELIST ?= soc_fabric.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --timescale 1ns/100ps
PASS_MSG ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# fails unless the pass message shows up on a line of its own
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: include/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// galois lfsr stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] res;
  int i;
  res = '0;
  for (i = 0; i < n; i++)
  begin
    res = {res[30:0], lfsr_state[0]};
    lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
  end
  return res;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
  end
endtask

// counts waitrequest-high cycles up to the completing edge
task automatic finish_transfer(output logic [31:0] data);
  int wait_cycles;
  wait_cycles = 0;
  @(negedge clock_50);
  while (waitrequest)
  begin
    wait_cycles++;
    @(negedge clock_50);
  end
  data = readdata;
  check_value("waitrequest cycles", 32'(wait_cycles), 32'd3);
  @(posedge clock_50);
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] be);
  logic [31:0] unused_rd;
  @(posedge clock_50);
  address <= addr;
  writedata <= data;
  byteenable <= be;
  write <= 1'b1;
  finish_transfer(unused_rd);
  write <= 1'b0;
  void'(ref_access(1'b1, addr, data, be));
endtask

task automatic bus_read(input logic [31:0] addr);
  logic [31:0] data;
  @(posedge clock_50);
  address <= addr;
  byteenable <= 4'hf;
  read <= 1'b1;
  finish_transfer(data);
  read <= 1'b0;
  got_q.push_back(data);
  exp_q.push_back(ref_access(1'b0, addr, 32'h0, 4'hf));
endtask

task automatic watch_cycles(input int limit);
  int cycles;
  cycles = 0;
  while (cycles < limit)
  begin
    @(posedge clock_50);
    cycles++;
  end
endtask

`endif

// File: dv/soc_fabric_tb.sv
`timescale 1ns/100ps

module soc_fabric_tb;

  localparam int n_fill = 32;
  localparam int n_merge = 32;
  localparam int n_reads = 40;
  localparam int n_io = 28;
  localparam int timer_reload = 6;
  localparam int timer_limit = timer_reload + 16;
  // five clocks per transfer as the bus tasks drive it
  localparam int cycle_limit = 8 + (n_fill + n_merge + n_reads + n_io) * 5 + timer_limit + 100;

  logic clock_50 = 1'b0;
  logic reset;
  logic [31:0] address;
  logic read;
  logic write;
  logic [31:0] writedata;
  logic [3:0] byteenable;
  logic [31:0] readdata;
  logic waitrequest;
  logic [15:0] switches;
  logic [15:0] leds;
  logic [2:0] interrupt;

  logic [31:0] lfsr_state;
  int errors = 0;
  int checks = 0;
  logic [31:0] exp_q[$];
  logic [31:0] got_q[$];
  // reference model state
  logic [31:0] shadow_ram [1024];
  logic [15:0] shadow_leds;
  logic [15:0] shadow_reload;
  logic [1:0] ref_fault;
  logic [1:0] ref_pending;

  always #4 clock_50 = ~clock_50;

  soc_fabric DUT (
    .clock_50(clock_50), .reset(reset), .address(address), .read(read), .write(write),
    .writedata(writedata), .byteenable(byteenable), .readdata(readdata),
    .waitrequest(waitrequest), .switches(switches), .leds(leds), .interrupt(interrupt)
  );

  // expected readdata of one access, updating the shadow state
  function automatic logic [31:0] ref_access(input logic wr, input logic [31:0] addr,
                                             input logic [31:0] wdata, input logic [3:0] be);
    logic [3:0] region;
    logic [3:0] idx;
    logic [31:0] rd;
    int b;
    region = addr[31:28];
    idx = addr[5:2];
    rd = '0;
    ref_fault = 2'b00;
    if (region != 4'd3 && region != 4'd4)
      ref_fault[0] = 1'b1;
    else if (region == 4'd4 && wr && (idx == 4'd0 || idx == 4'd3))
      ref_fault[1] = 1'b1;
    if (ref_fault == 2'b00)
    begin
      if (region == 4'd3)
      begin
        for (b = 0; b < 4; b++)
          if (wr && be[b])
            shadow_ram[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
        rd = shadow_ram[addr[11:2]];
      end
      else if (wr)
      begin
        for (b = 0; b < 2; b++)
        begin
          if (idx == 4'd1 && be[b])
            shadow_leds[8*b +: 8] = wdata[8*b +: 8];
          if (idx == 4'd2 && be[b])
            shadow_reload[8*b +: 8] = wdata[8*b +: 8];
        end
      end
      else
      begin
        case (idx)
          4'd0: rd = {16'h0000, switches};
          4'd1: rd = {16'h0000, shadow_leds};
          4'd2: rd = {16'h0000, shadow_reload};
          4'd3:
          begin
            rd = {30'h0, ref_pending};
            ref_pending = 2'b00;
          end
          default: rd = '0;
        endcase
      end
    end
    return rd;
  endfunction

  function automatic logic [2:0] ref_irq();
    if (ref_fault != 2'b00)
      return {1'b0, ref_fault};
    else if (ref_pending != 2'b00)
      return {1'b1, ref_pending};
    else
      return 3'b000;
  endfunction

  function automatic logic [31:0] ram_addr(input logic [9:0] word);
    return {4'd3, 16'h0000, word, 2'b00};
  endfunction

  function automatic logic [31:0] io_addr(input logic [3:0] idx);
    return {4'd4, 22'h0, idx, 2'b00};
  endfunction

  `include "tb_util.svh"

  task automatic compare_irq();
    @(negedge clock_50);
    check_value("interrupt", 32'(interrupt), 32'(ref_irq()));
  endtask

  task automatic wait_for_timer(input int limit);
    int n;
    n = 0;
    @(negedge clock_50);
    while (!interrupt[0] && n < limit)
    begin
      @(negedge clock_50);
      n++;
    end
    if (interrupt[0])
      ref_pending[0] = 1'b1;
    else
    begin
      errors++;
      $display("timer interrupt did not appear within %0d cycles", limit);
    end
  endtask

  task automatic ram_traffic();
    logic [9:0] used[$];
    int i;
    // full words first so merges never land on unknown bytes
    for (i = 0; i < n_fill; i++)
    begin
      used.push_back(10'(rand_bits(10)));
      bus_write(ram_addr(used[i]), rand_bits(32), 4'hf);
    end
    for (i = 0; i < n_merge; i++)
      bus_write(ram_addr(used[rand_bits(5)]), rand_bits(32), 4'(rand_bits(4)));
    for (i = 0; i < n_reads; i++)
      bus_read(ram_addr(used[rand_bits(5)]));
    compare_irq();
  endtask

  task automatic leds_and_reload();
    bus_write(io_addr(4'd1), 32'h0000a5c3, 4'b0011);
    bus_read(io_addr(4'd1));
    bus_write(io_addr(4'd1), 32'h00007e00, 4'b0010);
    bus_read(io_addr(4'd1));
    bus_write(io_addr(4'd1), 32'hffff0000, 4'b1100);
    bus_read(io_addr(4'd1));
    bus_write(io_addr(4'd1), rand_bits(32), 4'b0001);
    bus_read(io_addr(4'd1));
    // large reloads so the timer stays quiet here
    bus_write(io_addr(4'd2), 32'h00009a00, 4'b0010);
    bus_read(io_addr(4'd2));
    bus_write(io_addr(4'd2), 32'h00000077, 4'b0001);
    bus_read(io_addr(4'd2));
    bus_write(io_addr(4'd2), 32'h00000000, 4'b0011);
    bus_read(io_addr(4'd2));
  endtask

  task automatic fault_handling();
    bus_read(32'h7000_0010);
    compare_irq();
    bus_read(io_addr(4'd1));
    compare_irq();
    bus_write(io_addr(4'd0), 32'hffffffff, 4'hf);
    compare_irq();
    bus_read(io_addr(4'd0));
    compare_irq();
    bus_write(io_addr(4'd3), 32'h00000003, 4'hf);
    compare_irq();
    bus_read(io_addr(4'd1));
    compare_irq();
  endtask

  task automatic io_interrupts();
    @(posedge clock_50);
    switches <= 16'ha5c3;
    // two sync flops plus the edge detect
    repeat (6) @(posedge clock_50);
    ref_pending[1] = 1'b1;
    compare_irq();
    bus_write(io_addr(4'd2), 32'(timer_reload), 4'b0011);
    wait_for_timer(timer_limit);
    compare_irq();
    bus_write(io_addr(4'd2), 32'h0, 4'b0011);
    bus_read(32'h9000_0000);
    compare_irq();
    bus_read(io_addr(4'd3));
    compare_irq();
    bus_read(io_addr(4'd0));
  endtask

  always @(negedge clock_50)
  begin
    while (got_q.size() > 0 && exp_q.size() > 0)
      check_value("readdata", got_q.pop_front(), exp_q.pop_front());
    if (!reset && !read && !write)
      check_value("leds", 32'(leds), 32'(shadow_leds));
  end

  initial
  begin
    watch_cycles(cycle_limit);
    $display("timeout after %0d cycles, the run did not finish", cycle_limit);
    $display("Finished with errors");
    $finish;
  end

  initial
  begin
    reset <= 1'b1;
    address <= '0;
    read <= 1'b0;
    write <= 1'b0;
    writedata <= '0;
    byteenable <= 4'h0;
    switches <= 16'h5a3c;
    lfsr_state = 32'h241d85a9;
    shadow_leds = 16'h0000;
    shadow_reload = 16'h0000;
    ref_fault = 2'b00;
    ref_pending = 2'b00;
    repeat (8) @(posedge clock_50);
    reset <= 1'b0;
    ram_traffic();
    leds_and_reload();
    fault_handling();
    io_interrupts();
    repeat (3) @(negedge clock_50);
    if (got_q.size() != 0 || exp_q.size() != 0)
    begin
      errors++;
      $display("some reads were never compared");
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: soc_fabric.f
+incdir+include
verilog/soc_pkg.sv
verilog/bus_decoder.sv
verilog/scratch_ram.sv
verilog/io_regs.sv
verilog/bus_response.sv
verilog/soc_fabric.sv
dv/soc_fabric_tb.sv

// File: verilog/bus_decoder.sv
`timescale 1ns/100ps

module bus_decoder (
  input  logic                          clock_50,
  input  logic                          reset,
  input  soc_pkg::soc_addr_t            address,
  input  logic                          read,
  input  logic                          write,
  input  logic [soc_pkg::data_w-1:0]    writedata,
  input  logic [3:0]                    byteenable,
  output logic                          ram_read,
  output logic                          ram_write,
  output logic                          io_read,
  output logic                          io_write,
  output soc_pkg::soc_addr_t            acc_addr,
  output logic [soc_pkg::data_w-1:0]    acc_wdata,
  output logic [3:0]                    acc_be,
  output logic                          start,
  output soc_pkg::cs_t                  cs,
  output logic [1:0]                    fault,
  input  logic                          done
);
  import soc_pkg::*;

  logic busy;
  logic accept;
  logic wr_ok;
  cs_t dec_cs;
  logic [1:0] dec_fault;

  // a held request is only taken once while idle
  assign accept = !busy && (read || write);

  always_comb
  begin
    case (address.region_v.region)
      region_ram: dec_cs = cs_ram;
      region_io: dec_cs = cs_io;
      default: dec_cs = cs_none;
    endcase
    dec_fault[0] = (dec_cs == cs_none);
    dec_fault[1] = write && (dec_cs == cs_io) && io_ro_mask[address.io_v.reg_idx];
  end

  // no write reaches a slave on a faulting access
  assign wr_ok = write && (dec_fault == 2'b00);

  always_ff @(posedge clock_50)
  begin
    if (reset)
    begin
      busy <= 1'b0;
      start <= 1'b0;
      ram_read <= 1'b0;
      ram_write <= 1'b0;
      io_read <= 1'b0;
      io_write <= 1'b0;
      cs <= cs_none;
      fault <= 2'b00;
    end
    else
    begin
      start <= 1'b0;
      ram_read <= 1'b0;
      ram_write <= 1'b0;
      io_read <= 1'b0;
      io_write <= 1'b0;
      fault <= 2'b00;
      if (accept)
      begin
        busy <= 1'b1;
        start <= 1'b1;
        cs <= dec_cs;
        fault <= dec_fault;
        ram_read <= read && (dec_cs == cs_ram);
        ram_write <= wr_ok && (dec_cs == cs_ram);
        io_read <= read && (dec_cs == cs_io);
        io_write <= wr_ok && (dec_cs == cs_io);
      end
      else if (busy && done)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge clock_50)
  begin
    if (accept)
    begin
      acc_addr <= address;
      acc_wdata <= writedata;
      acc_be <= byteenable;
    end
  end

endmodule

// File: verilog/bus_response.sv
`timescale 1ns/100ps

module bus_response (
  input  logic                          clock_50,
  input  logic                          reset,
  input  logic                          start,
  input  soc_pkg::cs_t                  cs,
  input  logic [1:0]                    fault,
  input  logic [soc_pkg::data_w-1:0]    ram_rdata,
  input  logic [soc_pkg::data_w-1:0]    io_rdata,
  input  logic [1:0]                    io_irq,
  input  logic                          read,
  input  logic                          write,
  output logic [soc_pkg::data_w-1:0]    readdata,
  output logic                          waitrequest,
  output logic                          done,
  output logic [2:0]                    interrupt
);
  import soc_pkg::*;

  logic start_d;
  logic [1:0] fault_q;
  logic [data_w-1:0] merged;

  always_comb
  begin
    case (cs)
      cs_ram: merged = ram_rdata;
      cs_io: merged = io_rdata;
      default: merged = '0;
    endcase
  end

  // slave data is ready one cycle after the strobe
  always_ff @(posedge clock_50)
  begin
    if (reset)
    begin
      start_d <= 1'b0;
      done <= 1'b0;
      fault_q <= 2'b00;
    end
    else
    begin
      start_d <= start;
      done <= start_d;
      if (start)
        fault_q <= fault;
    end
  end

  always_ff @(posedge clock_50)
  begin
    if (start_d)
      readdata <= (fault_q != 2'b00) ? '0 : merged;
  end

  assign waitrequest = (read || write) && !done;

  // faults outrank io sources
  always_comb
  begin
    if (|fault_q)
      interrupt = {1'b0, fault_q};
    else if (|io_irq)
      interrupt = {1'b1, io_irq};
    else
      interrupt = 3'b000;
  end

endmodule

// File: verilog/io_regs.sv
`timescale 1ns/100ps

module io_regs (
  input  logic                          clock_50,
  input  logic                          reset,
  input  logic                          io_read,
  input  logic                          io_write,
  input  soc_pkg::soc_addr_t            acc_addr,
  input  logic [soc_pkg::data_w-1:0]    acc_wdata,
  input  logic [3:0]                    acc_be,
  input  logic [15:0]                   switches,
  output logic [15:0]                   leds,
  output logic [soc_pkg::data_w-1:0]    io_rdata,
  output logic [1:0]                    io_irq
);
  import soc_pkg::*;

  logic [15:0] sw_meta;
  logic [15:0] sw_sync;
  logic [15:0] sw_prev;
  logic [timer_w-1:0] reload;
  logic [timer_w-1:0] count;
  logic [1:0] pending;
  logic [1:0] set_bits;
  logic [3:0] idx;
  logic timer_tick;

  function automatic logic [15:0] merge_bytes(input logic [15:0] old_val,
                                              input logic [15:0] new_val,
                                              input logic [1:0] be);
    logic [15:0] res;
    res = old_val;
    if (be[0])
      res[7:0] = new_val[7:0];
    if (be[1])
      res[15:8] = new_val[15:8];
    return res;
  endfunction

  assign idx = acc_addr.io_v.reg_idx;
  assign timer_tick = (reload != '0) && (count <= timer_w'(1));
  assign set_bits = {sw_sync != sw_prev, timer_tick};
  assign io_irq = pending;

  // switch sync preloaded on reset so a static input raises nothing
  always_ff @(posedge clock_50)
  begin
    if (reset)
    begin
      sw_meta <= switches;
      sw_sync <= switches;
      sw_prev <= switches;
    end
    else
    begin
      sw_meta <= switches;
      sw_sync <= sw_meta;
      sw_prev <= sw_sync;
    end
  end

  always_ff @(posedge clock_50)
  begin
    if (reset)
    begin
      leds <= 16'h0000;
      reload <= '0;
      count <= '0;
      pending <= 2'b00;
    end
    else
    begin
      if (io_write && idx == io_leds)
        leds <= merge_bytes(leds, acc_wdata[15:0], acc_be[1:0]);
      // a new reload restarts the count
      if (io_write && idx == io_reload)
      begin
        reload <= merge_bytes(reload, acc_wdata[15:0], acc_be[1:0]);
        count <= merge_bytes(reload, acc_wdata[15:0], acc_be[1:0]);
      end
      else if (timer_tick)
        count <= reload;
      else if (reload != '0)
        count <= count - timer_w'(1);
      // a new event wins over a clearing status read
      if (io_read && idx == io_status)
        pending <= set_bits;
      else
        pending <= pending | set_bits;
    end
  end

  always_ff @(posedge clock_50)
  begin
    if (io_read)
    begin
      case (idx)
        io_switches: io_rdata <= {16'h0000, sw_sync};
        io_leds: io_rdata <= {16'h0000, leds};
        io_reload: io_rdata <= {{(data_w-timer_w){1'b0}}, reload};
        io_status: io_rdata <= {30'h0, pending};
        default: io_rdata <= '0;
      endcase
    end
  end

endmodule

// File: verilog/scratch_ram.sv
`timescale 1ns/100ps

module scratch_ram (
  input  logic                          clock_50,
  input  logic                          ram_read,
  input  logic                          ram_write,
  input  soc_pkg::soc_addr_t            acc_addr,
  input  logic [soc_pkg::data_w-1:0]    acc_wdata,
  input  logic [3:0]                    acc_be,
  output logic [soc_pkg::data_w-1:0]    ram_rdata
);
  import soc_pkg::*;

  logic [data_w-1:0] mem [ram_words];
  logic [ram_aw-1:0] word_idx;

  // upper offset bits alias onto the same words
  assign word_idx = acc_addr.region_v.offset[ram_aw-1:0];

  always_ff @(posedge clock_50)
  begin
    if (ram_write)
    begin
      if (acc_be[0])
        mem[word_idx][7:0] <= acc_wdata[7:0];
      if (acc_be[1])
        mem[word_idx][15:8] <= acc_wdata[15:8];
      if (acc_be[2])
        mem[word_idx][23:16] <= acc_wdata[23:16];
      if (acc_be[3])
        mem[word_idx][31:24] <= acc_wdata[31:24];
    end
  end

  // read data holds until the next read strobe
  always_ff @(posedge clock_50)
  begin
    if (ram_read)
      ram_rdata <= mem[word_idx];
  end

endmodule

// File: verilog/soc_fabric.sv
`timescale 1ns/100ps

module soc_fabric (
  input  logic                          clock_50,
  input  logic                          reset,
  input  soc_pkg::soc_addr_t            address,
  input  logic                          read,
  input  logic                          write,
  input  logic [soc_pkg::data_w-1:0]    writedata,
  input  logic [3:0]                    byteenable,
  output logic [soc_pkg::data_w-1:0]    readdata,
  output logic                          waitrequest,
  input  logic [15:0]                   switches,
  output logic [15:0]                   leds,
  output logic [2:0]                    interrupt
);
  import soc_pkg::*;

  logic ram_read;
  logic ram_write;
  logic io_read;
  logic io_write;
  soc_addr_t acc_addr;
  logic [data_w-1:0] acc_wdata;
  logic [3:0] acc_be;
  logic start;
  cs_t cs;
  logic [1:0] fault;
  logic done;
  logic [data_w-1:0] ram_rdata;
  logic [data_w-1:0] io_rdata;
  logic [1:0] io_irq;

  bus_decoder dec0 (
    .clock_50(clock_50), .reset(reset), .address(address), .read(read), .write(write),
    .writedata(writedata), .byteenable(byteenable),
    .ram_read(ram_read), .ram_write(ram_write), .io_read(io_read), .io_write(io_write),
    .acc_addr(acc_addr), .acc_wdata(acc_wdata), .acc_be(acc_be),
    .start(start), .cs(cs), .fault(fault), .done(done)
  );

  scratch_ram ram0 (
    .clock_50(clock_50), .ram_read(ram_read), .ram_write(ram_write),
    .acc_addr(acc_addr), .acc_wdata(acc_wdata), .acc_be(acc_be),
    .ram_rdata(ram_rdata)
  );

  io_regs io0 (
    .clock_50(clock_50), .reset(reset), .io_read(io_read), .io_write(io_write),
    .acc_addr(acc_addr), .acc_wdata(acc_wdata), .acc_be(acc_be),
    .switches(switches), .leds(leds), .io_rdata(io_rdata), .io_irq(io_irq)
  );

  bus_response resp0 (
    .clock_50(clock_50), .reset(reset), .start(start), .cs(cs), .fault(fault),
    .ram_rdata(ram_rdata), .io_rdata(io_rdata), .io_irq(io_irq),
    .read(read), .write(write),
    .readdata(readdata), .waitrequest(waitrequest), .done(done), .interrupt(interrupt)
  );

endmodule

// File: verilog/soc_pkg.sv
package soc_pkg;

  // bus geometry
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // scratch ram
  localparam int ram_words = 1024;
  localparam int ram_aw = 10;

  // address regions in the top nibble
  localparam logic [3:0] region_ram = 4'd3;
  localparam logic [3:0] region_io = 4'd4;

  // chip select codes
  typedef logic [3:0] cs_t;

  localparam cs_t cs_none = 4'd0;
  localparam cs_t cs_ram = 4'd3;
  localparam cs_t cs_io = 4'd4;

  // io register indices in address bits 5:2
  localparam logic [3:0] io_switches = 4'd0;
  localparam logic [3:0] io_leds = 4'd1;
  localparam logic [3:0] io_reload = 4'd2;
  localparam logic [3:0] io_status = 4'd3;

  // one bit per index set for each read only register
  localparam logic [15:0] io_ro_mask = 16'h0009;

  localparam int timer_w = 16;

  // same bus word seen as a memory region or as an io register
  typedef union packed {
    struct packed {
      logic [3:0] region;
      logic [addr_w-7:0] offset;
      logic [1:0] byte_sel;
    } region_v;
    struct packed {
      logic [3:0] region;
      logic [addr_w-11:0] unused;
      logic [3:0] reg_idx;
      logic [1:0] byte_sel;
    } io_v;
  } soc_addr_t;

endpackage
